/* verilog.f */
+incdir+tests
common/fpPkg.sv
fpAdd/fpAlignShift.sv
fpAdd/fpMantAdd.sv
fpNorm/fpLeadZero.sv
fpNorm/fpNormalizeShift.sv
fpNorm/fpRoundPack.sv
verilog/fpUnpack.sv
verilog/fpAddSubTop.sv
tests/fpAddSubTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f verilog.f --top-module fpAddSubTb -Mdir obj_dir \
	&& ./obj_dir/VfpAddSubTb \
	|| exit 1

/* tests/tbFpModel.svh */
`ifndef TB_FP_MODEL_SVH
`define TB_FP_MODEL_SVH

// All-ones exponent with a nonzero fraction
function automatic logic nanValue(input logic [15:0] v);
	return v[14:10] == 5'h1F && v[9:0] != 10'h0;
endfunction

function automatic logic infiniteValue(input logic [15:0] v);
	return v[14:10] == 5'h1F && v[9:0] == 10'h0;
endfunction

// Subnormals count as zero
function automatic logic zeroOrSubnormal(input logic [15:0] v);
	return v[14:10] == 5'h00;
endfunction

// Round an exact magnitude (units of 2^(emin-25)) to 11 bits, nearest even
function automatic logic [15:0] roundToHalf(input logic sign, input longint mag, input int emin);
	int p;
	int e;
	int sh;
	longint q;
	longint rem;
	longint half;
	p = 0;
	for (int i = 0; i < 64; i++)
	begin
		if (mag[i])
			p = i;                                  // Highest set bit
	end
	e = p + emin - 10;                              // Biased exponent of the leading one
	if (p > 10)
	begin
		sh = p - 10;
		q = mag >> sh;
		rem = mag - (q << sh);
		half = longint'(1) << (sh - 1);
		if (rem > half || (rem == half && q[0]))
			q = q + 1;
		if (q == 2048)
		begin
			q = 1024;                               // Carry out of the mantissa
			e = e + 1;
		end
	end
	else
		q = mag << (10 - p);                        // Exact, no rounding needed
	if (e <= 0)
		return {sign, 15'h0000};                    // Flush to signed zero
	if (e >= 31)
		return {sign, 5'h1F, 10'h000};              // Overflow
	return {sign, e[4:0], q[9:0]};
endfunction

// Expected result of a op b
function automatic logic [15:0] expectedSum(input logic [15:0] a, input logic [15:0] b,
	input logic sub);
	logic sa;
	logic sb;
	int emin;
	longint va;
	longint vb;
	longint total;
	sa = a[15];
	sb = b[15] ^ sub;                               // Subtract as add of negated b
	if (nanValue(a) || nanValue(b))
		return 16'h7E00;
	if (infiniteValue(a) && infiniteValue(b) && sa != sb)
		return 16'h7E00;
	if (infiniteValue(a))
		return {sa, 5'h1F, 10'h000};
	if (infiniteValue(b))
		return {sb, 5'h1F, 10'h000};
	if (zeroOrSubnormal(a) && zeroOrSubnormal(b))
		return {sa & sb, 15'h0000};
	emin = (a[14:10] < b[14:10]) ? int'(a[14:10]) : int'(b[14:10]);
	va = zeroOrSubnormal(a) ? 0 : longint'({1'b1, a[9:0]}) << (int'(a[14:10]) - emin);
	vb = zeroOrSubnormal(b) ? 0 : longint'({1'b1, b[9:0]}) << (int'(b[14:10]) - emin);
	if (sa)
		va = -va;
	if (sb)
		vb = -vb;
	total = va + vb;
	if (total == 0)
		return 16'h0000;                            // Exact cancel is +0
	return roundToHalf(total < 0, (total < 0) ? -total : total, emin);
endfunction

`endif

/* tests/fpAddSubTb.sv */
module fpAddSubTb;

	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic rstN;
	logic inVal;
	fpPkg::opE op;
	logic [15:0] a;
	logic [15:0] b;
	logic outVal;
	logic [15:0] result;

	logic [15:0] expQ[$];                   // Expected results in flight
	int issueQ[$];                          // Sampling cycle of each
	int cycleCnt = 0;
	int issuedCount = 0;
	int checkedCount = 0;
	logic [31:0] lcgState = 32'd65;

	`include "tbFpModel.svh"

	fpAddSubTop UUT (
		.clk    (clk),
		.rstN   (rstN),
		.inVal  (inVal),
		.op     (op),
		.a      (a),
		.b      (b),
		.outVal (outVal),
		.result (result)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;             // 40 ns period
	end

	function automatic logic [15:0] nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[30:15];
	endfunction

	task automatic stopWithFailure(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] want);
		if (got !== want)
			stopWithFailure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want));
	endtask

	task automatic sendOp(input fpPkg::opE o, input logic [15:0] x, input logic [15:0] y);
		@(posedge clk);
		inVal <= 1'b1;
		op <= o;
		a <= x;
		b <= y;
		issuedCount++;
	endtask

	// Edge that samples the last operation
	task automatic closeBurst();
		@(posedge clk);
		inVal <= 1'b0;
	endtask

	task automatic drainPipe();
		int waited;
		waited = 0;
		while (checkedCount != issuedCount)
		begin
			@(negedge clk);
			waited++;
			if (waited > 10)
				stopWithFailure("Pipeline did not return all results");
		end
	endtask

	// Scoreboard and watchdog
	always @(posedge clk)
	begin
		cycleCnt = cycleCnt + 1;
		if (cycleCnt > 16 + issuedCount + 3 + 50)
			stopWithFailure("Timeout, run took too many cycles");
		else if (rstN)
		begin
			if (outVal && expQ.size() == 0)
				stopWithFailure("outVal was high with no operation in flight");
			else if (outVal && cycleCnt - issueQ[0] != 3)
				stopWithFailure("outVal came before the third cycle");
			else if (outVal)
			begin
				checkValue("result", result, expQ.pop_front());
				void'(issueQ.pop_front());
				checkedCount++;
			end
			if (issueQ.size() != 0 && cycleCnt - issueQ[0] >= 3)
				stopWithFailure("outVal missing three cycles after inVal");
			if (inVal)
			begin
				expQ.push_back(expectedSum(a, b, op == fpPkg::OpSub));
				issueQ.push_back(cycleCnt);
			end
		end
	end

	task automatic resetAndLatency();
		int waited;
		for (int i = 0; i < 16; i++)
		begin
			@(posedge clk);
			if (i > 0)
				checkValue("outVal", 16'(outVal), 16'h0000);
		end
		rstN <= 1'b1;
		sendOp(fpPkg::OpAdd, 16'h3C00, 16'h3C00);   // 1.0 + 1.0
		closeBurst();
		waited = 0;
		while (!outVal)
		begin
			@(posedge clk);
			waited++;
			if (waited > 10)
				stopWithFailure("No outVal after the first addition");
		end
		checkValue("latency", 16'(waited), 16'd3);
		checkValue("result", result, 16'h4000);
		drainPipe();
	endtask

	task automatic normalArith();
		sendOp(fpPkg::OpAdd, 16'h4200, 16'h3E00);   // Same exponent
		sendOp(fpPkg::OpAdd, 16'h5640, 16'h5640);   // Carry out
		sendOp(fpPkg::OpSub, 16'h4500, 16'h4100);
		sendOp(fpPkg::OpAdd, 16'hC500, 16'h4100);
		sendOp(fpPkg::OpAdd, 16'h7000, 16'h3C00);   // Difference 13
		sendOp(fpPkg::OpAdd, 16'h7800, 16'h0400);   // Difference above 15
		sendOp(fpPkg::OpSub, 16'h7800, 16'h3C00);
		sendOp(fpPkg::OpSub, 16'h3C00, 16'h5000);   // b larger
		sendOp(fpPkg::OpSub, 16'h4248, 16'h4248);   // Exact cancel
		sendOp(fpPkg::OpAdd, 16'hC248, 16'h4248);
		sendOp(fpPkg::OpSub, 16'hBC00, 16'hBC00);
		closeBurst();
		drainPipe();
	endtask

	task automatic cancelShifts();
		for (int j = 0; j < 10; j++)
			sendOp(fpPkg::OpSub, 16'h3C00 | (16'h1 << j), 16'h3C00);   // Shifts 11 down to 2
		sendOp(fpPkg::OpSub, 16'h3E00, 16'h3400);   // Shift 1
		sendOp(fpPkg::OpSub, 16'h3C00, 16'h3BFF);   // 1.0 - 0.99951
		sendOp(fpPkg::OpSub, 16'h4000, 16'h3FFF);
		sendOp(fpPkg::OpAdd, 16'hBC00, 16'h3BFF);
		sendOp(fpPkg::OpSub, 16'h3BFF, 16'h3C01);
		closeBurst();
		drainPipe();
	endtask

	task automatic roundingCases();
		sendOp(fpPkg::OpAdd, 16'h3C00, 16'h1000);   // Tie, stays even
		sendOp(fpPkg::OpAdd, 16'h3C01, 16'h1000);   // Tie, up to even
		sendOp(fpPkg::OpAdd, 16'h3C01, 16'h3C00);
		sendOp(fpPkg::OpAdd, 16'h3C03, 16'h3C00);
		sendOp(fpPkg::OpAdd, 16'h3C00, 16'h1001);   // Just above tie
		sendOp(fpPkg::OpAdd, 16'h3FFF, 16'h1000);   // Carry into exponent
		sendOp(fpPkg::OpSub, 16'h3C00, 16'h0C00);
		sendOp(fpPkg::OpSub, 16'h4000, 16'h1001);
		closeBurst();
		drainPipe();
	endtask

	task automatic specialValues();
		sendOp(fpPkg::OpAdd, 16'h7E00, 16'h3C00);   // NaN operands
		sendOp(fpPkg::OpSub, 16'h3C00, 16'h7C01);
		sendOp(fpPkg::OpAdd, 16'hFE00, 16'h7C00);
		sendOp(fpPkg::OpSub, 16'h7C00, 16'h7C00);   // Inf - inf
		sendOp(fpPkg::OpAdd, 16'h7C00, 16'hFC00);
		sendOp(fpPkg::OpSub, 16'hFC00, 16'h7C00);   // Same sign, stays -inf
		sendOp(fpPkg::OpAdd, 16'h7C00, 16'h3C00);   // Inf with finite
		sendOp(fpPkg::OpSub, 16'hFC00, 16'h4000);
		sendOp(fpPkg::OpSub, 16'h3C00, 16'h7C00);
		sendOp(fpPkg::OpAdd, 16'h7BFF, 16'h7BFF);   // Overflow
		sendOp(fpPkg::OpSub, 16'hFBFF, 16'h7BFF);
		sendOp(fpPkg::OpAdd, 16'h7BFF, 16'h5000);
		sendOp(fpPkg::OpAdd, 16'h0001, 16'h3C00);   // Subnormal as zero
		sendOp(fpPkg::OpAdd, 16'h03FF, 16'h0000);
		sendOp(fpPkg::OpAdd, 16'h8001, 16'h8000);
		sendOp(fpPkg::OpSub, 16'h0001, 16'h0001);
		sendOp(fpPkg::OpSub, 16'h0400, 16'h0401);   // Flushed results
		sendOp(fpPkg::OpSub, 16'h0800, 16'h0600);
		sendOp(fpPkg::OpSub, 16'h0401, 16'h0400);
		closeBurst();
		drainPipe();
	endtask

	task automatic randomStream();
		logic [15:0] x;
		logic [15:0] y;
		logic [15:0] sel;
		for (int i = 0; i < 200; i++)
		begin
			x = nextRandom();
			y = nextRandom();
			sel = nextRandom();
			sendOp(fpPkg::opE'(sel[15]), x, y);
		end
		closeBurst();
		drainPipe();
	endtask

	initial
	begin
		rstN = 1'b0;
		inVal = 1'b0;
		op = fpPkg::OpAdd;
		a = 16'h0000;
		b = 16'h0000;
		resetAndLatency();
		normalArith();
		cancelShifts();
		roundingCases();
		specialValues();
		randomStream();
		if (checkedCount == issuedCount && expQ.size() == 0)
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
		else
			stopWithFailure("Some operations were never checked");
	end

endmodule

/* verilog/fpAddSubTop.sv */
module fpAddSubTop (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       inVal,
	input  fpPkg::opE                  op,
	input  logic [fpPkg::Width-1:0]    a,
	input  logic [fpPkg::Width-1:0]    b,
	output logic                       outVal,
	output logic [fpPkg::Width-1:0]    result
);

	// Decode to execute
	logic                        decVal;
	logic                        bigSign;
	logic                        effSub;
	logic [fpPkg::ExpW-1:0]      bigExp;
	logic [fpPkg::ManW:0]        bigMant;
	logic [fpPkg::ManW:0]        smallMant;
	logic [fpPkg::ShiftW-1:0]    expDiff;
	fpPkg::classE                decCls;
	logic                        decSign;

	// Execute to result
	logic                        exeVal;
	logic                        sumSign;
	logic [fpPkg::ExpW-1:0]      sumExp;
	logic [fpPkg::WorkW-1:0]     sumMant;
	fpPkg::classE                exeCls;
	logic                        exeSign;

	fpUnpack uDec (
		.clk       (clk),
		.rstN      (rstN),
		.inVal     (inVal),
		.op        (op),
		.a         (a),
		.b         (b),
		.decVal    (decVal),
		.bigSign   (bigSign),
		.effSub    (effSub),
		.bigExp    (bigExp),
		.bigMant   (bigMant),
		.smallMant (smallMant),
		.expDiff   (expDiff),
		.specCls   (decCls),
		.specSign  (decSign)
	);

	fpMantAdd uExe (
		.clk       (clk),
		.rstN      (rstN),
		.decVal    (decVal),
		.bigSign   (bigSign),
		.effSub    (effSub),
		.bigExp    (bigExp),
		.bigMant   (bigMant),
		.smallMant (smallMant),
		.expDiff   (expDiff),
		.specCls   (decCls),
		.specSign  (decSign),
		.exeVal    (exeVal),
		.sumSign   (sumSign),
		.sumExp    (sumExp),
		.sumMant   (sumMant),
		.specClsQ  (exeCls),
		.specSignQ (exeSign)
	);

	fpRoundPack uRes (
		.clk      (clk),
		.rstN     (rstN),
		.exeVal   (exeVal),
		.sumSign  (sumSign),
		.sumExp   (sumExp),
		.sumMant  (sumMant),
		.specCls  (exeCls),
		.specSign (exeSign),
		.outVal   (outVal),
		.result   (result)
	);

endmodule

/* verilog/fpUnpack.sv */
module fpUnpack (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          inVal,
	input  fpPkg::opE                     op,
	input  logic [fpPkg::Width-1:0]       a,
	input  logic [fpPkg::Width-1:0]       b,
	output logic                          decVal,
	output logic                          bigSign,
	output logic                          effSub,
	output logic [fpPkg::ExpW-1:0]        bigExp,
	output logic [fpPkg::ManW:0]          bigMant,     // Hidden bit included
	output logic [fpPkg::ManW:0]          smallMant,
	output logic [fpPkg::ShiftW-1:0]      expDiff,     // Saturated at 15
	output fpPkg::classE                  specCls,
	output logic                          specSign
);

	logic                          aSign;
	logic                          bSign;             // Op folded in
	fpPkg::classE                  aCls;
	fpPkg::classE                  bCls;
	logic [fpPkg::Width-2:0]       aMag;
	logic [fpPkg::Width-2:0]       bMag;
	logic                          swap;
	logic [fpPkg::ExpW-1:0]        loExp;
	logic [fpPkg::ExpW-1:0]        hiExp;
	logic [fpPkg::ExpW-1:0]        diffFull;
	fpPkg::classE                  specClsC;
	logic                          specSignC;

	function automatic fpPkg::classE classify(input logic [fpPkg::Width-1:0] v);
		logic [fpPkg::ExpW-1:0] e;
		e = v[fpPkg::Width-2 -: fpPkg::ExpW];
		if (e == '0)
			return fpPkg::ClsZero;                  // Subnormals count as zero
		else if (e == fpPkg::ExpW'(fpPkg::ExpMax))
			return (v[fpPkg::ManW-1:0] != '0) ? fpPkg::ClsNan : fpPkg::ClsInf;
		else
			return fpPkg::ClsNorm;
	endfunction

	assign aSign = a[fpPkg::Width-1];
	assign bSign = b[fpPkg::Width-1] ^ (op == fpPkg::OpSub);
	assign aCls = classify(a);
	assign bCls = classify(b);

	// Flushed magnitudes for ordering
	assign aMag = (aCls == fpPkg::ClsZero) ? '0 : a[fpPkg::Width-2:0];
	assign bMag = (bCls == fpPkg::ClsZero) ? '0 : b[fpPkg::Width-2:0];
	assign swap = bMag > aMag;

	assign hiExp = swap ? bMag[fpPkg::Width-2 -: fpPkg::ExpW] : aMag[fpPkg::Width-2 -: fpPkg::ExpW];
	assign loExp = swap ? aMag[fpPkg::Width-2 -: fpPkg::ExpW] : bMag[fpPkg::Width-2 -: fpPkg::ExpW];
	assign diffFull = hiExp - loExp;            // Never negative after ordering

	// Special result of the pair
	always_comb
	begin
		specClsC = fpPkg::ClsNorm;
		specSignC = 1'b0;
		if (aCls == fpPkg::ClsNan || bCls == fpPkg::ClsNan)
			specClsC = fpPkg::ClsNan;
		else if (aCls == fpPkg::ClsInf && bCls == fpPkg::ClsInf && aSign != bSign)
			specClsC = fpPkg::ClsNan;               // Inf minus inf
		else if (aCls == fpPkg::ClsInf || bCls == fpPkg::ClsInf)
		begin
			specClsC = fpPkg::ClsInf;
			specSignC = (aCls == fpPkg::ClsInf) ? aSign : bSign;
		end
		else if (aCls == fpPkg::ClsZero && bCls == fpPkg::ClsZero)
		begin
			specClsC = fpPkg::ClsZero;
			specSignC = aSign & bSign;              // -0 only if both negative
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
			decVal <= 1'b0;
		else
			decVal <= inVal;
	end

	// Payload, loads with the strobe
	always_ff @(posedge clk)
	begin
		if (inVal)
		begin
			bigSign <= swap ? bSign : aSign;
			effSub <= aSign ^ bSign;
			bigExp <= hiExp;
			bigMant <= (swap ? bMag == '0 : aMag == '0) ? '0 :
				{1'b1, (swap ? bMag[fpPkg::ManW-1:0] : aMag[fpPkg::ManW-1:0])};
			smallMant <= (swap ? aMag == '0 : bMag == '0) ? '0 :
				{1'b1, (swap ? aMag[fpPkg::ManW-1:0] : bMag[fpPkg::ManW-1:0])};
			expDiff <= (diffFull > 5'd15) ? 4'hF : diffFull[fpPkg::ShiftW-1:0];
			specCls <= specClsC;
			specSign <= specSignC;
		end
	end

	// Shift never exceeds the big exponent, ordering held
	expDiffBound: assert property (@(posedge clk) disable iff (!rstN)
		decVal && specCls == fpPkg::ClsNorm |-> 5'(expDiff) <= bigExp);

endmodule

/* fpNorm/fpRoundPack.sv */
module fpRoundPack (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          exeVal,
	input  logic                          sumSign,
	input  logic [fpPkg::ExpW-1:0]        sumExp,
	input  logic [fpPkg::WorkW-1:0]       sumMant,
	input  fpPkg::classE                  specCls,
	input  logic                          specSign,
	output logic                          outVal,
	output logic [fpPkg::Width-1:0]       result
);

	logic [fpPkg::ShiftW-1:0]   lzCount;
	logic [fpPkg::WorkW-1:0]    normMant;
	logic signed [6:0]          expWide;
	logic signed [6:0]          expFinal;
	logic                       guard;
	logic                       roundUp;
	logic [fpPkg::ManW+1:0]     rounded;              // Extra bit catches carry out
	logic [fpPkg::ManW-1:0]     frac;
	logic [fpPkg::Width-1:0]    resultC;

	fpLeadZero uLz (
		.sumMant (sumMant),
		.lzCount (lzCount)
	);

	fpNormalizeShift uNorm (
		.sumMant  (sumMant),
		.lzCount  (lzCount),
		.normMant (normMant)
	);

	// Carry bit position is one above the big exponent
	assign expWide = 7'(sumExp) + 7'd1 - 7'(lzCount);

	// Nearest even, leading 1 at bit 14, lsb at bit 4
	assign guard = normMant[3];
	assign roundUp = guard & (|normMant[2:0] | normMant[4]);
	assign rounded = {1'b0, normMant[fpPkg::WorkW-1:4]} + 12'(roundUp);
	assign frac = rounded[fpPkg::ManW+1] ? rounded[fpPkg::ManW:1] : rounded[fpPkg::ManW-1:0];
	assign expFinal = expWide + 7'(rounded[fpPkg::ManW+1]);    // Renormalize on carry

	always_comb
	begin
		if (sumMant == '0)
			resultC = {sumSign, 15'b0};
		else if (expFinal <= 0)
			resultC = {sumSign, 15'b0};                  // Flush to zero
		else if (expFinal >= fpPkg::ExpMax)
			resultC = {sumSign, 5'h1F, 10'b0};           // Overflow
		else
			resultC = {sumSign, expFinal[fpPkg::ExpW-1:0], frac};

		// Special results win
		case (specCls)
			fpPkg::ClsNan: resultC = fpPkg::QNan;
			fpPkg::ClsInf: resultC = {specSign, 5'h1F, 10'b0};
			fpPkg::ClsZero: resultC = {specSign, 15'b0};
			default: ;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			outVal <= 1'b0;
			result <= '0;
		end
		else
		begin
			outVal <= exeVal;
			if (exeVal)
				result <= resultC;
		end
	end

	// Shifter must bring a nonzero sum to the carry bit
	normLeads: assert property (@(posedge clk) disable iff (!rstN)
		exeVal && sumMant != '0 |-> normMant[fpPkg::WorkW-1]);

	outValKnown: assert property (@(posedge clk) disable iff (!rstN)
		!$isunknown(outVal));

endmodule

/* fpNorm/fpNormalizeShift.sv */
module fpNormalizeShift (
	input  logic [fpPkg::WorkW-1:0]     sumMant,
	input  logic [fpPkg::ShiftW-1:0]    lzCount,
	output logic [fpPkg::WorkW-1:0]     normMant
);

	logic [fpPkg::WorkW-1:0] lvl2;
	logic [fpPkg::WorkW-1:0] lvl3;

	// Coarse step, 0 | 4 | 8 | 12
	always_comb
	begin
		case (lzCount[3:2])
			2'b00: lvl2 = sumMant;
			2'b01: lvl2 = {sumMant[fpPkg::WorkW-5:0], 4'b0};
			2'b10: lvl2 = {sumMant[fpPkg::WorkW-9:0], 8'b0};
			default: lvl2 = {sumMant[fpPkg::WorkW-13:0], 12'b0};
		endcase
	end

	// Fine step, 0 | 1 | 2 | 3
	always_comb
	begin
		case (lzCount[1:0])
			2'b00: lvl3 = lvl2;
			2'b01: lvl3 = {lvl2[fpPkg::WorkW-2:0], 1'b0};
			2'b10: lvl3 = {lvl2[fpPkg::WorkW-3:0], 2'b0};
			default: lvl3 = {lvl2[fpPkg::WorkW-4:0], 3'b0};
		endcase
	end

	// Keep the sticky alive in the low bit
	assign normMant = {lvl3[fpPkg::WorkW-1:1], lvl3[0] | sumMant[0]};

endmodule

/* fpNorm/fpLeadZero.sv */
module fpLeadZero (
	input  logic [fpPkg::WorkW-1:0]     sumMant,
	output logic [fpPkg::ShiftW-1:0]    lzCount
);

	// Scan upwards, highest set bit wins
	always_comb
	begin
		lzCount = 4'd15;                            // All-zero mantissa
		for (int i = 0; i < fpPkg::WorkW; i++)
		begin
			if (sumMant[i])
				lzCount = fpPkg::ShiftW'(fpPkg::WorkW - 1 - i);
		end
	end

endmodule

/* fpAdd/fpMantAdd.sv */
module fpMantAdd (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          decVal,
	input  logic                          bigSign,
	input  logic                          effSub,
	input  logic [fpPkg::ExpW-1:0]        bigExp,
	input  logic [fpPkg::ManW:0]          bigMant,
	input  logic [fpPkg::ManW:0]          smallMant,
	input  logic [fpPkg::ShiftW-1:0]      expDiff,
	input  fpPkg::classE                  specCls,
	input  logic                          specSign,
	output logic                          exeVal,
	output logic                          sumSign,
	output logic [fpPkg::ExpW-1:0]        sumExp,
	output logic [fpPkg::WorkW-1:0]       sumMant,
	output fpPkg::classE                  specClsQ,
	output logic                          specSignQ
);

	logic [fpPkg::WorkW-1:0] alignMant;
	logic [fpPkg::WorkW-1:0] bigWork;
	logic [fpPkg::WorkW-1:0] sumC;

	fpAlignShift uAlign (
		.smallMant (smallMant),
		.expDiff   (expDiff),
		.alignMant (alignMant)
	);

	assign bigWork = {1'b0, bigMant, 3'b000};
	// Big magnitude leads, difference stays positive
	assign sumC = effSub ? bigWork - alignMant : bigWork + alignMant;

	always_ff @(posedge clk)
	begin
		if (!rstN)
			exeVal <= 1'b0;
		else
			exeVal <= decVal;
	end

	always_ff @(posedge clk)
	begin
		if (decVal)
		begin
			sumSign <= (effSub && sumC == '0) ? 1'b0 : bigSign;    // Exact cancel gives +0
			sumExp <= bigExp;
			sumMant <= sumC;
			specClsQ <= specCls;
			specSignQ <= specSign;
		end
	end

endmodule

/* fpAdd/fpAlignShift.sv */
module fpAlignShift (
	input  logic [fpPkg::ManW:0]        smallMant,
	input  logic [fpPkg::ShiftW-1:0]    expDiff,
	output logic [fpPkg::WorkW-1:0]     alignMant
);

	logic [fpPkg::WorkW-1:0] placed;
	logic [fpPkg::WorkW-1:0] shifted;
	logic [fpPkg::WorkW-1:0] lostMask;
	logic                    sticky;

	// Carry bit clear, GRS zero before shifting
	assign placed = {1'b0, smallMant, 3'b000};
	assign shifted = placed >> expDiff;

	// Bits that fall off the bottom
	assign lostMask = (15'd1 << expDiff) - 15'd1;    // All ones at 15
	assign sticky = |(placed & lostMask);

	assign alignMant = {shifted[fpPkg::WorkW-1:1], shifted[0] | sticky};

endmodule

/* common/fpPkg.sv */
package fpPkg;

	// Half precision layout
	localparam int Width = 16;
	localparam int ExpW = 5;
	localparam int ManW = 10;
	localparam int ExpBias = 15;
	localparam int ExpMax = 31;             // All-ones exponent, inf/NaN

	// Working mantissa, carry | hidden | 10 fraction | guard | round | sticky
	localparam int WorkW = 15;
	localparam int ShiftW = 4;              // Shift amounts 0..15

	// Canonical quiet NaN
	localparam logic [Width-1:0] QNan = 16'h7E00;

	// Operation, travels one bit wide
	typedef enum logic
	{
		OpAdd = 1'b0,
		OpSub = 1'b1
	} opE;

	// Operand or result class
	typedef enum logic [1:0]
	{
		ClsZero = 2'd0,
		ClsNorm = 2'd1,                     // Arithmetic path applies
		ClsInf  = 2'd2,
		ClsNan  = 2'd3
	} classE;

endpackage
